/* build.f */
lsu_pkg.sv
lsu_ad.sv
lsu_sq.sv
lsu_ex.sv
lsu_wb.sv
lsu_top.sv
tb_lsu.sv

/* lsu_ad.sv */
// LSU decode and address generation

`timescale 1ns/1ps

module lsu_ad (
    input  logic                clk,
    input  logic                n_rst,

    // Reservation station
    input  logic                i_valid,
    input  lsu_pkg::data_t      i_insn,
    input  lsu_pkg::data_t      i_src_a,
    input  lsu_pkg::data_t      i_src_b,
    input  lsu_pkg::tag_t       i_tag,
    output logic                o_stall,

    // Store queue status and head entry
    input  logic                i_sq_full,
    input  logic                i_retire_req,
    input  lsu_pkg::lsu_func_t  i_retire_func,
    input  lsu_pkg::addr_t      i_retire_addr,
    input  lsu_pkg::data_t      i_retire_data,
    output logic                o_retire_ack,

    // New store allocation
    output logic                o_alloc_en,
    output lsu_pkg::lsu_func_t  o_alloc_func,
    output lsu_pkg::addr_t      o_alloc_addr,
    output lsu_pkg::data_t      o_alloc_data,

    // To execute stage
    output logic                o_ad_valid,
    output logic                o_ad_is_store,
    output lsu_pkg::lsu_func_t  o_ad_func,
    output lsu_pkg::tag_t       o_ad_tag,
    output lsu_pkg::addr_t      o_ad_addr,
    output lsu_pkg::data_t      o_ad_data
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic                is_load;
    logic                is_store;
    logic                accept;
    lsu_pkg::data_t      imm_i;
    lsu_pkg::data_t      imm_s;
    lsu_pkg::addr_t      addr;
    lsu_pkg::lsu_func_t  lsu_func;
    lsu_pkg::lsu_func_t  mux_func;
    lsu_pkg::addr_t      mux_addr;

    assign opcode   = i_insn[6:0];
    assign funct3   = i_insn[14:12];
    assign is_load  = (opcode == lsu_pkg::OPCODE_LOAD);
    assign is_store = (opcode == lsu_pkg::OPCODE_STORE);

    // Sign-extended I-type and S-type immediates
    assign imm_i = {{21{i_insn[31]}}, i_insn[30:25], i_insn[24:20]};
    assign imm_s = {{21{i_insn[31]}}, i_insn[30:25], i_insn[11:7]};

    assign addr = i_src_a + (is_store ? imm_s : imm_i);

    // Retirement always wins over a new op
    assign o_stall      = i_sq_full | i_retire_req;
    assign o_retire_ack = i_retire_req;
    assign accept       = i_valid & ~o_stall;

    // Function from funct3, width by load/store
    always_comb begin
        case (funct3)
            lsu_pkg::FUNCT3_B:  lsu_func = is_store ? lsu_pkg::LSU_FUNC_SB : lsu_pkg::LSU_FUNC_LB;
            lsu_pkg::FUNCT3_H:  lsu_func = is_store ? lsu_pkg::LSU_FUNC_SH : lsu_pkg::LSU_FUNC_LH;
            lsu_pkg::FUNCT3_W:  lsu_func = is_store ? lsu_pkg::LSU_FUNC_SW : lsu_pkg::LSU_FUNC_LW;
            lsu_pkg::FUNCT3_BU: lsu_func = lsu_pkg::LSU_FUNC_LBU;
            lsu_pkg::FUNCT3_HU: lsu_func = lsu_pkg::LSU_FUNC_LHU;
            default:            lsu_func = is_store ? lsu_pkg::LSU_FUNC_SW : lsu_pkg::LSU_FUNC_LW;
        endcase
    end

    // Pipeline mux, retiring store or new load
    always_comb begin
        mux_func = i_retire_req ? i_retire_func : lsu_func;
        mux_addr = i_retire_req ? i_retire_addr : addr;
    end

    // Store queue allocation
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_alloc_en <= 1'b0;
        end else begin
            o_alloc_en <= accept & is_store;
        end
    end

    always_ff @(posedge clk) begin
        o_alloc_func <= lsu_func;
        o_alloc_addr <= addr;
        o_alloc_data <= i_src_b;
    end

    // New stores do not enter the pipeline until they retire
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_ad_valid <= 1'b0;
        end else begin
            o_ad_valid <= i_retire_req | (accept & is_load);
        end
    end

    always_ff @(posedge clk) begin
        o_ad_is_store <= i_retire_req;
        o_ad_func     <= mux_func;
        o_ad_tag      <= i_tag;
        o_ad_addr     <= mux_addr;
        o_ad_data     <= i_retire_data;
    end

endmodule

/* lsu_ex.sv */
// LSU execute stage and data memory

`timescale 1ns/1ps

module lsu_ex (
    input  logic                clk,
    input  logic                n_rst,

    // From decode stage
    input  logic                i_ad_valid,
    input  logic                i_ad_is_store,
    input  lsu_pkg::lsu_func_t  i_ad_func,
    input  lsu_pkg::tag_t       i_ad_tag,
    input  lsu_pkg::addr_t      i_ad_addr,
    input  lsu_pkg::data_t      i_ad_data,

    // To result stage, loads only
    output logic                o_ex_valid,
    output lsu_pkg::lsu_func_t  o_ex_func,
    output lsu_pkg::tag_t       o_ex_tag,
    output logic [1:0]          o_ex_byte_off,
    output lsu_pkg::data_t      o_ex_word
);

    lsu_pkg::data_t  dmem [lsu_pkg::DMEM_WORDS];

    logic [7:0]      idx;
    logic [3:0]      byte_en;
    lsu_pkg::data_t  wr_data;
    logic            wr_en;

    assign idx   = i_ad_addr[9:2];
    assign wr_en = i_ad_valid & i_ad_is_store;

    // Lane enables and lane-replicated write data
    always_comb begin
        case (i_ad_func)
            lsu_pkg::LSU_FUNC_SB: begin
                byte_en = 4'b0001 << i_ad_addr[1:0];
                wr_data = {4{i_ad_data[7:0]}};
            end
            lsu_pkg::LSU_FUNC_SH: begin
                byte_en = i_ad_addr[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{i_ad_data[15:0]}};
            end
            lsu_pkg::LSU_FUNC_SW: begin
                byte_en = 4'b1111;
                wr_data = i_ad_data;
            end
            default: begin
                byte_en = 4'b0000;
                wr_data = i_ad_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (wr_en && byte_en[i]) begin
                dmem[idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end

    // Read sees the old word if a write hits the same cycle
    always_ff @(posedge clk) begin
        o_ex_word     <= dmem[idx];
        o_ex_func     <= i_ad_func;
        o_ex_tag      <= i_ad_tag;
        o_ex_byte_off <= i_ad_addr[1:0];
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_ex_valid <= 1'b0;
        end else begin
            o_ex_valid <= i_ad_valid & ~i_ad_is_store;
        end
    end

endmodule

/* lsu_pkg.sv */
// Load/store unit shared definitions

package lsu_pkg;

    // Datapath widths
    localparam int DATA_WIDTH   = 32;
    localparam int ADDR_WIDTH   = 32;
    localparam int TAG_WIDTH    = 5;

    // Store queue sizing
    localparam int SQ_DEPTH     = 4;
    localparam int SQ_IDX_WIDTH = 2;

    // Data memory is indexed by address bits 9 to 2
    localparam int DMEM_WORDS   = 256;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;
    typedef logic [2:0]            lsu_func_t;

    // LSU function codes
    localparam lsu_func_t LSU_FUNC_LB  = 3'd0;
    localparam lsu_func_t LSU_FUNC_LH  = 3'd1;
    localparam lsu_func_t LSU_FUNC_LW  = 3'd2;
    localparam lsu_func_t LSU_FUNC_LBU = 3'd3;
    localparam lsu_func_t LSU_FUNC_LHU = 3'd4;
    localparam lsu_func_t LSU_FUNC_SB  = 3'd5;
    localparam lsu_func_t LSU_FUNC_SH  = 3'd6;
    localparam lsu_func_t LSU_FUNC_SW  = 3'd7;

    // RV32 major opcodes
    localparam logic [6:0] OPCODE_LOAD  = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE = 7'b0100011;

    // Load/store funct3 codes
    localparam logic [2:0] FUNCT3_B  = 3'b000;
    localparam logic [2:0] FUNCT3_H  = 3'b001;
    localparam logic [2:0] FUNCT3_W  = 3'b010;
    localparam logic [2:0] FUNCT3_BU = 3'b100;
    localparam logic [2:0] FUNCT3_HU = 3'b101;

endpackage

/* lsu_sq.sv */
// LSU store queue

`timescale 1ns/1ps

module lsu_sq (
    input  logic                clk,
    input  logic                n_rst,

    // Allocation from decode stage
    input  logic                i_alloc_en,
    input  lsu_pkg::lsu_func_t  i_alloc_func,
    input  lsu_pkg::addr_t      i_alloc_addr,
    input  lsu_pkg::data_t      i_alloc_data,

    // Commit pulse from the core
    input  logic                i_commit,

    // Retire handshake with decode stage
    input  logic                i_retire_ack,
    output logic                o_full,
    output logic                o_retire_req,
    output lsu_pkg::lsu_func_t  o_retire_func,
    output lsu_pkg::addr_t      o_retire_addr,
    output lsu_pkg::data_t      o_retire_data
);

    lsu_pkg::lsu_func_t  sq_func [lsu_pkg::SQ_DEPTH];
    lsu_pkg::addr_t      sq_addr [lsu_pkg::SQ_DEPTH];
    lsu_pkg::data_t      sq_data [lsu_pkg::SQ_DEPTH];

    logic [lsu_pkg::SQ_IDX_WIDTH-1:0] head;
    logic [lsu_pkg::SQ_IDX_WIDTH-1:0] tail;
    logic [lsu_pkg::SQ_IDX_WIDTH:0]   count;
    logic [lsu_pkg::SQ_IDX_WIDTH:0]   commit_cnt;
    logic                             push;
    logic                             pop;
    logic                             commit_ok;

    assign push      = i_alloc_en;
    assign pop       = i_retire_ack & o_retire_req;
    // Only entries not yet committed can take a commit
    assign commit_ok = i_commit & (commit_cnt != count);

    // A store already in the alloc register still needs a slot
    assign o_full = (count == lsu_pkg::SQ_DEPTH) ||
                    (i_alloc_en && (count == lsu_pkg::SQ_DEPTH - 1));

    assign o_retire_req  = (commit_cnt != '0);
    assign o_retire_func = sq_func[head];
    assign o_retire_addr = sq_addr[head];
    assign o_retire_data = sq_data[head];

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            sq_func[tail] <= i_alloc_func;
            sq_addr[tail] <= i_alloc_addr;
            sq_data[tail] <= i_alloc_data;
        end
    end

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            count <= '0;
        end else if (push && !pop) begin
            count <= count + 1'b1;
        end else if (pop && !push) begin
            count <= count - 1'b1;
        end
    end

    // Committed count tracks the retire-ready prefix of the queue
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            commit_cnt <= '0;
        end else if (commit_ok && !pop) begin
            commit_cnt <= commit_cnt + 1'b1;
        end else if (pop && !commit_ok) begin
            commit_cnt <= commit_cnt - 1'b1;
        end
    end

endmodule

/* lsu_top.sv */
// Load/store unit top level

`timescale 1ns/1ps

module lsu_top (
    input  logic            clk,
    input  logic            n_rst,

    // Reservation station
    input  logic            i_valid,
    input  lsu_pkg::data_t  i_insn,
    input  lsu_pkg::data_t  i_src_a,
    input  lsu_pkg::data_t  i_src_b,
    input  lsu_pkg::tag_t   i_tag,
    output logic            o_stall,

    // Core commit
    input  logic            i_commit,

    // Load result
    output logic            o_result_valid,
    output lsu_pkg::tag_t   o_result_tag,
    output lsu_pkg::data_t  o_result_data
);

    // Decode stage to store queue
    logic                alloc_en;
    lsu_pkg::lsu_func_t  alloc_func;
    lsu_pkg::addr_t      alloc_addr;
    lsu_pkg::data_t      alloc_data;

    // Store queue head and status
    logic                sq_full;
    logic                retire_req;
    logic                retire_ack;
    lsu_pkg::lsu_func_t  retire_func;
    lsu_pkg::addr_t      retire_addr;
    lsu_pkg::data_t      retire_data;

    // Decode to execute
    logic                ad_valid;
    logic                ad_is_store;
    lsu_pkg::lsu_func_t  ad_func;
    lsu_pkg::tag_t       ad_tag;
    lsu_pkg::addr_t      ad_addr;
    lsu_pkg::data_t      ad_data;

    // Execute to result
    logic                ex_valid;
    lsu_pkg::lsu_func_t  ex_func;
    lsu_pkg::tag_t       ex_tag;
    logic [1:0]          ex_byte_off;
    lsu_pkg::data_t      ex_word;

    lsu_ad u_lsu_ad (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_valid        (i_valid),
        .i_insn         (i_insn),
        .i_src_a        (i_src_a),
        .i_src_b        (i_src_b),
        .i_tag          (i_tag),
        .o_stall        (o_stall),
        .i_sq_full      (sq_full),
        .i_retire_req   (retire_req),
        .i_retire_func  (retire_func),
        .i_retire_addr  (retire_addr),
        .i_retire_data  (retire_data),
        .o_retire_ack   (retire_ack),
        .o_alloc_en     (alloc_en),
        .o_alloc_func   (alloc_func),
        .o_alloc_addr   (alloc_addr),
        .o_alloc_data   (alloc_data),
        .o_ad_valid     (ad_valid),
        .o_ad_is_store  (ad_is_store),
        .o_ad_func      (ad_func),
        .o_ad_tag       (ad_tag),
        .o_ad_addr      (ad_addr),
        .o_ad_data      (ad_data)
    );

    lsu_sq u_lsu_sq (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_alloc_en     (alloc_en),
        .i_alloc_func   (alloc_func),
        .i_alloc_addr   (alloc_addr),
        .i_alloc_data   (alloc_data),
        .i_commit       (i_commit),
        .i_retire_ack   (retire_ack),
        .o_full         (sq_full),
        .o_retire_req   (retire_req),
        .o_retire_func  (retire_func),
        .o_retire_addr  (retire_addr),
        .o_retire_data  (retire_data)
    );

    lsu_ex u_lsu_ex (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_ad_valid     (ad_valid),
        .i_ad_is_store  (ad_is_store),
        .i_ad_func      (ad_func),
        .i_ad_tag       (ad_tag),
        .i_ad_addr      (ad_addr),
        .i_ad_data      (ad_data),
        .o_ex_valid     (ex_valid),
        .o_ex_func      (ex_func),
        .o_ex_tag       (ex_tag),
        .o_ex_byte_off  (ex_byte_off),
        .o_ex_word      (ex_word)
    );

    lsu_wb u_lsu_wb (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_ex_valid     (ex_valid),
        .i_ex_func      (ex_func),
        .i_ex_tag       (ex_tag),
        .i_ex_byte_off  (ex_byte_off),
        .i_ex_word      (ex_word),
        .o_result_valid (o_result_valid),
        .o_result_tag   (o_result_tag),
        .o_result_data  (o_result_data)
    );

endmodule

/* lsu_wb.sv */
// LSU load result stage

`timescale 1ns/1ps

module lsu_wb (
    input  logic                clk,
    input  logic                n_rst,

    // From execute stage
    input  logic                i_ex_valid,
    input  lsu_pkg::lsu_func_t  i_ex_func,
    input  lsu_pkg::tag_t       i_ex_tag,
    input  logic [1:0]          i_ex_byte_off,
    input  lsu_pkg::data_t      i_ex_word,

    // Load result
    output logic                o_result_valid,
    output lsu_pkg::tag_t       o_result_tag,
    output lsu_pkg::data_t      o_result_data
);

    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    lsu_pkg::data_t  ld_data;

    // Byte by full offset, halfword by offset bit 1
    assign ld_byte = i_ex_word[8*i_ex_byte_off +: 8];
    assign ld_half = i_ex_byte_off[1] ? i_ex_word[31:16] : i_ex_word[15:0];

    always_comb begin
        case (i_ex_func)
            lsu_pkg::LSU_FUNC_LB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
            lsu_pkg::LSU_FUNC_LBU: ld_data = {24'b0, ld_byte};
            lsu_pkg::LSU_FUNC_LH:  ld_data = {{16{ld_half[15]}}, ld_half};
            lsu_pkg::LSU_FUNC_LHU: ld_data = {16'b0, ld_half};
            default:               ld_data = i_ex_word;
        endcase
    end

    always_ff @(posedge clk) begin
        o_result_tag  <= i_ex_tag;
        o_result_data <= ld_data;
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_ex_valid;
        end
    end

endmodule

/* tb_lsu.sv */
// Load/store unit testbench

`timescale 1ns/1ps

module tb_lsu;

    localparam int NUM_OPS = 133;

    logic        clk;
    logic        n_rst;
    logic        i_valid;
    logic [31:0] i_insn;
    logic [31:0] i_src_a;
    logic [31:0] i_src_b;
    logic [4:0]  i_tag;
    logic        i_commit;
    logic        o_stall;
    logic        o_result_valid;
    logic [4:0]  o_result_tag;
    logic [31:0] o_result_data;

    // Byte-wide model of the data memory over address bits 9 to 0
    logic [7:0]  mem_model [1024];
    // Stores waiting for commit in age order
    logic [2:0]  pend_f3 [$];
    logic [31:0] pend_ea [$];
    logic [31:0] pend_data [$];
    // Expected load results in issue order
    logic [4:0]  exp_tag_q [$];
    logic [31:0] exp_data_q [$];
    int          exp_due_q [$];

    int          cyc;
    int          seed;
    logic [4:0]  next_tag;

    lsu_top u_lsu_top (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_valid        (i_valid),
        .i_insn         (i_insn),
        .i_src_a        (i_src_a),
        .i_src_b        (i_src_b),
        .i_tag          (i_tag),
        .o_stall        (o_stall),
        .i_commit       (i_commit),
        .o_result_valid (o_result_valid),
        .o_result_tag   (o_result_tag),
        .o_result_data  (o_result_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic fail_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
        $display("TEST FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_text(input string msg);
        $display("ERROR %s", msg);
        $display("TEST FAILED");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] load_insn(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd2, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_insn(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    // funct3 selects the width and bit 2 marks a zero-extended load
    function automatic logic [31:0] expect_load(input logic [2:0] f3, input logic [31:0] ea);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        a = ea[9:0];
        b = mem_model[a];
        h = {mem_model[{a[9:1], 1'b1}], mem_model[{a[9:1], 1'b0}]};
        case (f3)
            3'b000:  return {{24{b[7]}}, b};
            3'b100:  return {24'b0, b};
            3'b001:  return {{16{h[15]}}, h};
            3'b101:  return {16'b0, h};
            default: return {mem_model[{a[9:2], 2'd3}], mem_model[{a[9:2], 2'd2}],
                             mem_model[{a[9:2], 2'd1}], mem_model[{a[9:2], 2'd0}]};
        endcase
    endfunction

    task automatic write_model(input logic [2:0] f3, input logic [31:0] ea, input logic [31:0] d);
        logic [9:0] a;
        a = ea[9:0];
        case (f3)
            3'b000: mem_model[a] = d[7:0];
            3'b001: begin
                mem_model[{a[9:1], 1'b0}] = d[7:0];
                mem_model[{a[9:1], 1'b1}] = d[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    mem_model[{a[9:2], 2'(i)}] = d[8*i +: 8];
                end
            end
        endcase
    endtask

    // One cycle of stimulus that starts and ends just after a falling edge
    task automatic step(input bit v, input bit is_load, input logic [31:0] insn,
                        input logic [31:0] a, input logic [31:0] b, input logic [2:0] f3,
                        input logic [31:0] ea, input bit cmt, output bit acc);
        i_valid  = v;
        i_insn   = insn;
        i_src_a  = a;
        i_src_b  = b;
        i_tag    = next_tag;
        i_commit = cmt;
        #1;
        acc = v && !o_stall;
        if (acc && is_load) begin
            exp_tag_q.push_back(next_tag);
            exp_data_q.push_back(expect_load(f3, ea));
            exp_due_q.push_back(cyc + 3);
        end
        if (acc) begin
            next_tag = next_tag + 1'b1;
        end
        // Loads taken after this edge are stalled until the write lands
        if (cmt && pend_f3.size() > 0) begin
            write_model(pend_f3.pop_front(), pend_ea.pop_front(), pend_data.pop_front());
        end
        @(negedge clk);
        i_valid  = 1'b0;
        i_commit = 1'b0;
    endtask

    task automatic idle(input int n);
        bit acc;
        repeat (n) step(0, 0, 32'h0, 32'h0, 32'h0, 3'd0, 32'h0, 0, acc);
    endtask

    task automatic issue_op(input bit is_load, input logic [2:0] f3, input logic [31:0] base,
                            input logic [11:0] imm, input logic [31:0] d);
        logic [31:0] ea;
        logic [31:0] insn;
        bit          acc;
        ea   = base + {{20{imm[11]}}, imm};
        insn = is_load ? load_insn(f3, imm) : store_insn(f3, imm);
        acc  = 0;
        while (!acc) begin
            step(1, is_load, insn, base, d, f3, ea, 0, acc);
        end
        if (!is_load) begin
            pend_f3.push_back(f3);
            pend_ea.push_back(ea);
            pend_data.push_back(d);
        end
    endtask

    // Commit the oldest store and check its single retire stall cycle
    task automatic commit_one();
        bit acc;
        idle(2);
        step(0, 0, 32'h0, 32'h0, 32'h0, 3'd0, 32'h0, 1, acc);
        assert (o_stall) else fail_text("o_stall not raised for a retire");
        idle(1);
        assert (!o_stall) else fail_text("o_stall held after the retire");
        idle(1);
    endtask

    // Load results checked at the falling edge
    always @(negedge clk) begin
        if (n_rst) begin
            if (o_result_valid) begin
                assert (exp_tag_q.size() > 0) else fail_text("result with no load in flight");
                assert (exp_due_q[0] == cyc) else fail_text("result arrived at the wrong cycle");
                assert (o_result_tag == exp_tag_q[0])
                    else fail_value("o_result_tag", 32'(o_result_tag), 32'(exp_tag_q[0]));
                assert (o_result_data == exp_data_q[0])
                    else fail_value("o_result_data", o_result_data, exp_data_q[0]);
                void'(exp_tag_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_due_q.pop_front());
            end else if (exp_due_q.size() > 0) begin
                assert (exp_due_q[0] != cyc) else fail_text("load result missing");
            end
        end
    end

    initial begin
        logic [2:0]  f3;
        logic [31:0] ea;
        logic [31:0] d;
        bit          acc;
        clk      = 1'b0;
        n_rst    = 1'b0;
        i_valid  = 1'b0;
        i_insn   = 32'h0;
        i_src_a  = 32'h0;
        i_src_b  = 32'h0;
        i_tag    = 5'h0;
        i_commit = 1'b0;
        cyc      = 0;
        seed     = 32'h487d;
        next_tag = 5'h0;

        fork
            begin
                repeat (20 * NUM_OPS) @(posedge clk);
                $display("ERROR timeout, the run did not finish in time");
                $display("TEST FAILED");
                $fatal(1, "timeout");
            end
        join_none

        repeat (4) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        // Quiet after reset
        for (int i = 0; i < 5; i++) begin
            assert (!o_stall && !o_result_valid) else fail_text("activity after reset");
            idle(1);
        end

        // SW then LW with negative immediates
        issue_op(0, 3'b010, 32'h180, 12'hff8, 32'hcafe_1234);
        commit_one();
        issue_op(1, 3'b010, 32'h190, 12'hfe8, 32'h0);
        idle(4);

        // Byte and halfword lanes
        issue_op(0, 3'b010, 32'h300, 12'h0, 32'h0);
        issue_op(0, 3'b010, 32'h304, 12'h0, 32'h0);
        commit_one();
        commit_one();
        issue_op(0, 3'b000, 32'h300, 12'h0, 32'h81);
        issue_op(0, 3'b000, 32'h300, 12'h1, 32'h22);
        issue_op(0, 3'b000, 32'h300, 12'h2, 32'hc3);
        issue_op(0, 3'b000, 32'h300, 12'h3, 32'h44);
        repeat (4) commit_one();
        issue_op(0, 3'b001, 32'h304, 12'h0, 32'h8001);
        issue_op(0, 3'b001, 32'h304, 12'h2, 32'h7ffe);
        repeat (2) commit_one();
        for (int i = 0; i < 4; i++) begin
            issue_op(1, 3'b000, 32'h300, 12'(i), 32'h0);
            issue_op(1, 3'b100, 32'h300, 12'(i), 32'h0);
        end
        issue_op(1, 3'b001, 32'h304, 12'h0, 32'h0);
        issue_op(1, 3'b101, 32'h304, 12'h0, 32'h0);
        issue_op(1, 3'b001, 32'h304, 12'h2, 32'h0);
        issue_op(1, 3'b101, 32'h304, 12'h2, 32'h0);
        issue_op(1, 3'b010, 32'h300, 12'h0, 32'h0);
        issue_op(1, 3'b010, 32'h304, 12'h0, 32'h0);
        idle(4);

        // Load ahead of an uncommitted store sees the older word
        issue_op(0, 3'b010, 32'h178, 12'h0, 32'h5555_aaaa);
        idle(2);
        issue_op(1, 3'b010, 32'h178, 12'h0, 32'h0);
        commit_one();
        issue_op(1, 3'b010, 32'h178, 12'h0, 32'h0);
        idle(4);

        // Full queue holds off a fifth store
        for (int i = 0; i < 4; i++) begin
            issue_op(0, 3'b010, 32'h340 + 32'(4 * i), 12'h0, 32'h1111_0000 + 32'(i));
        end
        idle(2);
        assert (o_stall) else fail_text("o_stall low with a full store queue");
        for (int i = 0; i < 3; i++) begin
            step(1, 0, store_insn(3'b010, 12'h0), 32'h350, 32'hdead, 3'b010, 32'h350, 0, acc);
            assert (!acc) else fail_text("store taken while the queue was full");
        end
        repeat (4) commit_one();
        for (int i = 0; i < 4; i++) begin
            issue_op(1, 3'b010, 32'h340 + 32'(4 * i), 12'h0, 32'h0);
        end
        idle(4);

        // Random phase over 16 words written first
        for (int i = 0; i < 16; i++) begin
            issue_op(0, 3'b010, 32'h200 + 32'(4 * i), 12'h0, $random(seed));
            commit_one();
        end
        for (int i = 0; i < 3; i++) begin
            f3 = 3'($unsigned($random(seed)) % 3);
            ea = 32'h200 + 32'(4 * ($unsigned($random(seed)) % 16)) +
                 (f3 == 3'b000 ? 32'($unsigned($random(seed)) % 4) :
                  f3 == 3'b001 ? 32'(2 * ($unsigned($random(seed)) % 2)) : 32'h0);
            issue_op(0, f3, ea, 12'h0, $random(seed));
        end
        idle(2);
        for (int i = 0; i < 60; i++) begin
            case ($unsigned($random(seed)) % 5)
                0:       f3 = 3'b000;
                1:       f3 = 3'b100;
                2:       f3 = 3'b001;
                3:       f3 = 3'b101;
                default: f3 = 3'b010;
            endcase
            ea = 32'h200 + 32'(4 * ($unsigned($random(seed)) % 16)) +
                 32'($unsigned($random(seed)) % 4);
            d  = 32'($unsigned($random(seed)) % 6 == 0 && pend_f3.size() > 0);
            step(1, 1, load_insn(f3, ea[11:0]), 32'h0, 32'h0, f3, ea, d[0], acc);
        end
        while (pend_f3.size() > 0) begin
            commit_one();
        end
        for (int i = 0; i < 16; i++) begin
            issue_op(1, 3'b010, 32'h200 + 32'(4 * i), 12'h0, 32'h0);
        end

        while (exp_due_q.size() > 0) begin
            idle(1);
        end
        idle(2);
        $display("TEST PASSED");
        $finish;
    end

endmodule
